// File: logic/ocyrus_pkg.sv
package ocyrus_pkg;

	// word geometry
	localparam int WIDTH = 8; // bits per word (even and at least 4)
	localparam int HALF_WIDTH = WIDTH / 2; // word clock high/low length in bit clocks
	localparam int BIT_COUNT_W = $clog2(WIDTH); // bit counter width

	// lock tracking
	localparam int LOCK_STROBES = 4; // aligned strobes seen before locked rises
	localparam int LOCK_COUNT_W = $clog2(LOCK_STROBES + 1); // strobe counter width

	// serial line level while idle or not yet locked
	localparam logic IDLE_LEVEL = 1'b1; // line idles high

	// one parallel word with the MSB sent first
	typedef logic [WIDTH-1:0] word_t;

	// lock FSM
	typedef enum logic [1:0] {
		LOCK_RESET    = 2'd0, // just out of reset
		LOCK_ALIGNING = 2'd1, // divider running and counting strobes
		LOCK_LOCKED   = 2'd2  // strobe aligned so lanes may load
	} lock_state_t;

endpackage

// File: logic/serdes_clock_gen.sv
module serdes_clock_gen
	import ocyrus_pkg::*;
(
	input  logic clock, // bit clock
	input  logic arst_n, // async reset, active low
	output logic strobe, // one bit clock wide, marks word boundary
	output logic word_clock_out, // bit clock / WIDTH
	output logic lock_ok // divider running and strobe aligned
);

	logic [BIT_COUNT_W-1:0] bit_count; // position inside the current word
	logic last_bit; // counter sits on its final bit
	logic half_bit; // counter sits on the last bit of the high half

	lock_state_t lock_state; // lock FSM state
	lock_state_t lock_state_next;
	logic [LOCK_COUNT_W-1:0] strobe_count; // strobes seen while aligning
	logic [LOCK_COUNT_W-1:0] strobe_count_next;

	assign last_bit = (bit_count == BIT_COUNT_W'(WIDTH - 1)); // wrap point
	assign half_bit = (bit_count == BIT_COUNT_W'(HALF_WIDTH - 1)); // word clock falls after this

	// bit counter, 0 .. WIDTH-1 then wrap
	// explicit wrap so WIDTH need not be a power of two
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			bit_count <= '0; // first word period starts at bit 0
		end else if (last_bit) begin
			bit_count <= '0; // wrap to the next word
		end else begin
			bit_count <= bit_count + 1'b1; // next bit
		end
	end

	// strobe is registered, so it is high while the counter reads 0
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			strobe <= 1'b0; // no strobe during the first partial period
		end else begin
			strobe <= last_bit; // one cycle in every WIDTH
		end
	end

	// word clock: set together with the strobe, cleared half a word later
	// first full period after reset stays low, so the first rise lines up with a strobe
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			word_clock_out <= 1'b0; // low out of reset
		end else if (last_bit) begin
			word_clock_out <= 1'b1; // rising edge seen in the strobe cycle
		end else if (half_bit) begin
			word_clock_out <= 1'b0; // falls after HALF_WIDTH high cycles
		end
	end

	// lock FSM next state
	always_comb begin
		lock_state_next = lock_state; // hold by default
		strobe_count_next = strobe_count;
		case (lock_state)
			LOCK_RESET: begin
				lock_state_next = LOCK_ALIGNING; // divider starts right away
				strobe_count_next = '0; // nothing counted yet
			end
			LOCK_ALIGNING: begin
				if (strobe) begin
					if (strobe_count == LOCK_COUNT_W'(LOCK_STROBES - 1)) begin
						lock_state_next = LOCK_LOCKED; // this was the last strobe needed
					end else begin
						strobe_count_next = strobe_count + 1'b1; // one more aligned word
					end
				end
			end
			LOCK_LOCKED: begin
				lock_state_next = LOCK_LOCKED; // only reset leaves this state
			end
			default: begin
				lock_state_next = LOCK_RESET; // unused encoding, start over
			end
		endcase
	end

	// lock FSM registers
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			lock_state <= LOCK_RESET;
			strobe_count <= '0;
		end else begin
			lock_state <= lock_state_next;
			strobe_count <= strobe_count_next;
		end
	end

	// high from the cycle after the LOCK_STROBES-th strobe
	assign lock_ok = (lock_state == LOCK_LOCKED); // decoded from a register, glitch free

endmodule

// File: logic/serializer_lane.sv
module serializer_lane
	import ocyrus_pkg::*;
(
	input  logic  clock, // bit clock
	input  logic  arst_n, // async reset, active low
	input  logic  strobe, // word boundary from the clock generator
	input  logic  lock_ok, // loads only while locked
	input  word_t word, // parallel word for this lane
	output logic  serial // serial line, MSB first
);

	logic  load; // take a new word at the end of this cycle
	word_t shift_q; // bits still to go out, top bit is on the line
	word_t shift_next; // shifter contents after this edge

	// words seen while not locked are dropped
	assign load = strobe & lock_ok;

	// load the whole word, or move everything up one place
	// the bottom fills with the idle level, so an unloaded lane stays idle
	always_comb begin
		if (load) begin
			shift_next = word; // MSB lands on top, goes out next cycle
		end else begin
			shift_next = {shift_q[WIDTH-2:0], IDLE_LEVEL}; // next lower bit moves up
		end
	end

	// shift register
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			shift_q <= {WIDTH{IDLE_LEVEL}}; // all idle until the first load
		end else begin
			shift_q <= shift_next;
		end
	end

	// serial output is a flop fed from the top of the next shifter value
	// MSB shows one cycle after the load edge, bit 0 in the strobe cycle
	// of the following word, so back-to-back words leave no gap
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			serial <= IDLE_LEVEL; // idle line out of reset
		end else begin
			serial <= shift_next[WIDTH-1]; // registered copy of the top bit
		end
	end

endmodule

// File: logic/ocyrus_double.sv
module ocyrus_double
	import ocyrus_pkg::*;
(
	input  logic  clock, // bit clock
	input  logic  arst_n, // async reset, active low
	input  word_t word1, // lane 1 parallel word
	input  word_t word2, // lane 2 parallel word
	output logic  word_clock_out, // word clock, bit clock / WIDTH
	output logic  serial1, // lane 1 serial line
	output logic  serial2, // lane 2 serial line
	output logic  locked // divider running and strobe aligned
);

	logic strobe; // word boundary, shared by both lanes
	logic lock_ok; // lock from the clock generator

	// one divider feeds both lanes, so the lanes stay word aligned
	serdes_clock_gen clock_gen (
		.clock          (clock),
		.arst_n         (arst_n),
		.strobe         (strobe),
		.word_clock_out (word_clock_out),
		.lock_ok        (lock_ok)
	);

	// lane 1, the D1 path
	serializer_lane lane1 (
		.clock   (clock),
		.arst_n  (arst_n),
		.strobe  (strobe),
		.lock_ok (lock_ok),
		.word    (word1),
		.serial  (serial1)
	);

	// lane 2, the D2 path
	// independent data, same strobe and lock as lane 1
	serializer_lane lane2 (
		.clock   (clock),
		.arst_n  (arst_n),
		.strobe  (strobe),
		.lock_ok (lock_ok),
		.word    (word2),
		.serial  (serial2)
	);

	// one lock for the whole block
	assign locked = lock_ok; // same signal the lanes load on

endmodule

// File: test/lane_model.svh
`ifndef LANE_MODEL_SVH
`define LANE_MODEL_SVH

// reference model for both serial lanes
// a word pushed in a strobe cycle goes out MSB first from the next cycle on
// both lanes share the strobe and so one bit counter serves both

word_t lane1_words[$]; // captured lane 1 words waiting for the line
word_t lane2_words[$]; // captured lane 2 words waiting for the line
word_t cur_word1; // lane 1 word on the line with the next bit at the top
word_t cur_word2; // lane 2 word on the line
int bits_left = 0; // bits of the current word still to go out

logic exp_bit1 = IDLE_LEVEL; // expected serial1 in this cycle
logic exp_bit2 = IDLE_LEVEL; // expected serial2 in this cycle

int words_captured = 0; // pairs pushed since the start of the run
int words_differing = 0; // pairs where the two lanes got different words

// forget everything on reset as the lanes go idle at once
task automatic clear_model();
	lane1_words.delete();
	lane2_words.delete();
	cur_word1 = '0;
	cur_word2 = '0;
	bits_left = 0;
	exp_bit1 = IDLE_LEVEL;
	exp_bit2 = IDLE_LEVEL;
endtask

// one bit clock of the model at mid cycle
// first the bit for this cycle and then the capture at the end of it
task automatic step_lanes(input logic capture, input word_t w1, input word_t w2);
	exp_bit1 = IDLE_LEVEL; // idle unless a word is going out
	exp_bit2 = IDLE_LEVEL;
	if (bits_left == 0 && lane1_words.size() > 0) begin
		cur_word1 = lane1_words.pop_front(); // next word starts right after the last bit
		cur_word2 = lane2_words.pop_front();
		bits_left = WIDTH;
	end
	if (bits_left > 0) begin
		exp_bit1 = cur_word1[WIDTH-1]; // MSB first
		exp_bit2 = cur_word2[WIDTH-1];
		cur_word1 = cur_word1 << 1; // lower bit moves up for the next cycle
		cur_word2 = cur_word2 << 1;
		bits_left = bits_left - 1;
	end
	if (capture) begin
		lane1_words.push_back(w1); // taken at the edge that ends this cycle
		lane2_words.push_back(w2);
		words_captured = words_captured + 1;
		if (w1 != w2) begin
			words_differing = words_differing + 1; // shows the lanes do not share data
		end
	end
endtask

`endif

// File: test/ocyrus_tb.sv
module ocyrus_tb
	import ocyrus_pkg::*;
();

	localparam int CLOCK_PERIOD = 8; // bit clock period
	localparam int RESET_CYCLES = 2; // cycles arst_n is held low
	localparam int HALF_WORD = WIDTH / 2; // expected word clock high and low length
	localparam int WORDS_FIRST = 14; // word pairs before the mid-run reset
	localparam int WORDS_SECOND = 10; // word pairs after it
	localparam int TEST_WORDS = WORDS_FIRST + WORDS_SECOND;
	localparam int RAND_SEED = 22;
	localparam int WATCHDOG_TIME = (LOCK_STROBES + TEST_WORDS + 4) * WIDTH * CLOCK_PERIOD * 2;

	// DUT ports
	logic clock;
	logic arst_n;
	word_t word1;
	word_t word2;
	logic word_clock_out;
	logic serial1;
	logic serial2;
	logic locked;

	// observation state is updated at the falling edge and read at the next rise
	logic checks_on = 1'b0; // set once reset has taken hold
	logic wc_prev = 1'b0; // word clock in the previous cycle
	logic wc_rise = 1'b0; // word clock rose in this cycle
	logic wc_changed = 1'b0; // word clock changed level in this cycle
	int wc_run = 0; // cycles the word clock has held its level including this one
	int ended_run = 0; // length of the run that ended when the level changed
	logic fall_seen = 1'b0; // a full high phase has ended since reset
	int rise_count = 0; // word clock rises since reset
	logic nth_rise_last = 1'b0; // previous cycle held the LOCK_STROBES-th rise
	logic lock_expected = 1'b0; // model of the locked output
	int locks_seen = 0; // lock acquisitions over the whole run

	`include "lane_model.svh"

	ocyrus_double dut (
		.clock          (clock),
		.arst_n         (arst_n),
		.word1          (word1),
		.word2          (word2),
		.word_clock_out (word_clock_out),
		.serial1        (serial1),
		.serial2        (serial2),
		.locked         (locked)
	);

	// bit clock
	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// prints the fail message and stops the run
	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// wrong value seen by an assertion
	task automatic report_mismatch(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		abort_run();
	endtask

	// word clock, lock and lane models sampled mid cycle
	always @(negedge clock) begin
		if (!arst_n) begin
			checks_on = 1'b1; // DUT has seen reset so outputs are defined
			wc_prev = 1'b0;
			wc_rise = 1'b0;
			wc_changed = 1'b0;
			wc_run = 0;
			ended_run = 0;
			fall_seen = 1'b0; // first low phase after reset is a full word long
			rise_count = 0;
			nth_rise_last = 1'b0;
			lock_expected = 1'b0;
			clear_model();
		end else begin
			wc_rise = word_clock_out && !wc_prev;
			wc_changed = (word_clock_out != wc_prev);
			if (wc_changed) begin
				ended_run = wc_run; // keep the finished run for the length check
				wc_run = 1;
			end else begin
				wc_run = wc_run + 1;
			end
			if (wc_changed && !word_clock_out) begin
				fall_seen = 1'b1;
			end
			if (nth_rise_last) begin
				lock_expected = 1'b1; // one cycle after the last aligning strobe
				locks_seen = locks_seen + 1;
			end
			if (wc_rise) begin
				rise_count = rise_count + 1;
			end
			nth_rise_last = wc_rise && (rise_count == LOCK_STROBES);
			step_lanes(wc_rise && lock_expected, word1, word2); // lanes load only while locked
			wc_prev = word_clock_out;
		end
	end

	// reset values while arst_n is low
	reset_values: assert property (@(posedge clock) disable iff (!checks_on)
		!arst_n |-> (!word_clock_out && !locked && serial1 == IDLE_LEVEL
			&& serial2 == IDLE_LEVEL))
		else report_mismatch("outputs not at their reset values during reset");

	// first cycle out of reset
	reset_release: assert property (@(posedge clock) disable iff (!checks_on)
		$rose(arst_n) |-> (!word_clock_out && !locked))
		else report_mismatch("word_clock_out or locked high right after reset");

	// lines stay idle until lock
	idle_until_locked: assert property (@(posedge clock) disable iff (!checks_on)
		!locked |-> (serial1 == IDLE_LEVEL && serial2 == IDLE_LEVEL))
		else report_mismatch("serial line left the idle level before lock");

	// word clock shape
	wc_high_len: assert property (@(posedge clock) disable iff (!checks_on)
		word_clock_out |-> wc_run <= HALF_WORD)
		else report_mismatch("word_clock_out high for too many cycles");

	wc_low_len: assert property (@(posedge clock) disable iff (!checks_on)
		(!word_clock_out && fall_seen) |-> wc_run <= HALF_WORD)
		else report_mismatch("word_clock_out low for too many cycles");

	wc_fall_len: assert property (@(posedge clock) disable iff (!checks_on)
		(wc_changed && !word_clock_out) |-> ended_run == HALF_WORD)
		else report_mismatch("word_clock_out high phase has the wrong length");

	wc_rise_len: assert property (@(posedge clock) disable iff (!checks_on)
		(wc_rise && fall_seen) |-> ended_run == HALF_WORD)
		else report_mismatch("word_clock_out low phase has the wrong length");

	// lock timing and hold
	lock_time: assert property (@(posedge clock) disable iff (!checks_on)
		locked == lock_expected)
		else report_mismatch("locked does not follow the strobe count");

	lock_held: assert property (@(posedge clock) disable iff (!checks_on)
		$fell(locked) |-> !arst_n)
		else report_mismatch("locked fell without a reset");

	// serial data against the model
	lane1_data: assert property (@(posedge clock) disable iff (!checks_on)
		serial1 == exp_bit1)
		else report_mismatch("serial1 differs from the lane 1 model");

	lane2_data: assert property (@(posedge clock) disable iff (!checks_on)
		serial2 == exp_bit2)
		else report_mismatch("serial2 differs from the lane 2 model");

	// reset low for a number of whole cycles
	task automatic hold_reset(input int cycles);
		@(posedge clock);
		arst_n <= 1'b0;
		repeat (cycles) @(posedge clock);
		arst_n <= 1'b1;
	endtask

	// new random pair after every word clock rise until count pairs were captured
	task automatic send_words(input int count);
		int target;
		target = words_captured + count;
		while (words_captured < target) begin
			@(posedge clock);
			if (wc_rise) begin
				word1 <= word_t'($urandom); // the old pair was taken at this edge
				word2 <= word_t'($urandom);
			end
		end
	endtask

	// end of run once every assertion has been reached
	task automatic finish_run();
		if (words_captured < TEST_WORDS || words_differing == 0 || locks_seen < 2) begin
			$display("not all checks were reached: %0d words captured, %0d differing, %0d locks",
				words_captured, words_differing, locks_seen);
			abort_run();
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	endtask

	// stimulus
	initial begin
		void'($urandom(RAND_SEED));
		arst_n <= 1'b0;
		word1 <= '0;
		word2 <= '0;
		hold_reset(RESET_CYCLES);
		send_words(WORDS_FIRST);
		repeat (3) @(posedge clock); // into the middle of a word
		hold_reset(RESET_CYCLES); // mid-run reset and a second lock
		send_words(WORDS_SECOND);
		repeat (2 * WIDTH) @(posedge clock); // last words leave the lanes
		finish_run();
	end

	// watchdog
	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
		abort_run();
	end

endmodule

// File: all.f
+incdir+test
logic/ocyrus_pkg.sv
logic/serdes_clock_gen.sv
logic/serializer_lane.sv
logic/ocyrus_double.sv
test/ocyrus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ocyrus testbench with Verilator
# exit status 0 only when the log holds no failure

set -u

cd "$(dirname "$0")" || exit 1

TOP=ocyrus_tb
BUILD_DIR=build
LOG_FILE=sim.log

# compile RTL and testbench into one executable
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module "$TOP" \
	--Mdir "$BUILD_DIR" \
	-o "$TOP" \
	-f all.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "build failed with status $build_status"
	exit 1
fi

if [ ! -x "$BUILD_DIR/$TOP" ]; then
	echo "simulation executable missing"
	exit 1
fi

# run and keep the log
"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

# decide on the log contents
if grep -q "TESTBENCH FAILED" "$LOG_FILE"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

echo "simulation finished without failure"
exit 0
